// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= invadersCoreTb
FILELIST  ?= verilog.f
OBJDIR    ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

// ==== dv/invadersCoreTb.sv ====
`default_nettype none
`timescale 1ns/1ps

module invadersCoreTb;

    import gamePkg::*;
    import videoPkg::*;

    localparam int FRAME_WIDTH  = 16;
    localparam int FRAME_HEIGHT = 8;
    localparam int WAIT_LIMIT   = 2 * FRAME_WIDTH * FRAME_HEIGHT;
    localparam int MIX_TRIALS   = 200;
    localparam coord_t HIT_X    = 10'd5; // Pixel where the sprites overlap.
    localparam coord_t HIT_Y    = 10'd3;

    typedef enum logic [2:0] {
        hitNone,
        hitKill,
        hitShot,
        hitRam,
        hitOut
    } hitKind_t;

    typedef struct packed {
        hitKind_t   hit;
        logic       startGame;
        logic       pause;
        logic       cheatN;
        gameState_t expState;
        stage_t     expStage;
        logic [1:0] expLives;
        scoreBcd_t  expScore;
    } scenario_t;

    logic       clk;
    logic       rstN;
    logic       startGame;
    logic       pause;
    logic       cheatN;
    objDraw_t   objDraw;
    objRgb_t    objRgb;
    rgb_t       backgroundRgb;
    coord_t     pixelX;
    coord_t     pixelY;
    logic       startOfFrame;
    rgb_t       pixelRgb;
    gameState_t gameState;
    stage_t     stage;
    logic [1:0] lives;
    scoreBcd_t  score;

    scenario_t scenarios[$];
    string     rowNames[$];

    invadersCore #(
        .FRAME_WIDTH  (FRAME_WIDTH),
        .FRAME_HEIGHT (FRAME_HEIGHT)
    ) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abortRun(input string reason);
        $display("FAIL: see errors above");
        $fatal(1, "%s", reason);
    endtask

    task automatic checkState(input string name, input gameState_t expected,
                              input gameState_t actual);
        if (actual !== expected) begin
            $display("[FAIL] %s: gameState expected %s, actual %s", name,
                     expected.name(), actual.name());
            abortRun("game state mismatch");
        end
    endtask

    task automatic checkStage(input string name, input stage_t expected, input stage_t actual);
        if (actual !== expected) begin
            $display("[FAIL] %s: stage expected %s, actual %s", name,
                     expected.name(), actual.name());
            abortRun("stage mismatch");
        end
    endtask

    task automatic checkLives(input string name, input logic [1:0] expected,
                              input logic [1:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s: lives expected %0d, actual %0d", name, expected, actual);
            abortRun("lives mismatch");
        end
    endtask

    task automatic checkScore(input string name, input scoreBcd_t expected,
                              input scoreBcd_t actual);
        if (actual !== expected) begin
            $display("[FAIL] %s: score expected %h, actual %h", name, expected, actual);
            abortRun("score mismatch");
        end
    endtask

    task automatic checkRgb(input string name, input rgb_t expected, input rgb_t actual);
        if (actual !== expected) begin
            $display("[FAIL] %s: pixelRgb expected %h, actual %h", name, expected, actual);
            abortRun("pixel colour mismatch");
        end
    endtask

    task automatic checkCoord(input string name, input string axis, input coord_t expected,
                              input coord_t actual);
        if (actual !== expected) begin
            $display("[FAIL] %s: %s expected %0d, actual %0d", name, axis, expected, actual);
            abortRun("pixel coordinate mismatch");
        end
    endtask

    task automatic waitForPixel(input coord_t x, input coord_t y);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!(pixelX == x && pixelY == y) && cycles < WAIT_LIMIT);
        if (pixelX != x || pixelY != y) begin
            abortRun($sformatf("timed out waiting for pixel (%0d,%0d)", x, y));
        end
    endtask

    // The start of frame pulse must coincide with pixel (0,0).
    task automatic waitForFrameStart(input string name);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (startOfFrame !== 1'b1 && cycles < WAIT_LIMIT);
        if (startOfFrame !== 1'b1) begin
            abortRun("timed out waiting for the start of a frame");
        end
        checkCoord(name, "pixelX at frame start", '0, pixelX);
        checkCoord(name, "pixelY at frame start", '0, pixelY);
    endtask

    function automatic objDraw_t drawFor(input hitKind_t kind);
        objDraw_t draw;
        draw = '0;
        case (kind)
            hitKill: {draw.playerMissile, draw.monster} = 2'b11;
            hitShot: {draw.player, draw.monsterMissile} = 2'b11;
            hitRam:  {draw.player, draw.monster} = 2'b11;
            hitOut:  {draw.playerMissile, draw.border} = 2'b11;
            default: draw = '0;
        endcase
        return draw;
    endfunction

    // Highest priority requester wins and the background fills the rest.
    function automatic rgb_t expectedColour(input objDraw_t draw, input objRgb_t colours,
                                            input rgb_t background);
        if (draw.player) return colours.player;
        if (draw.playerMissile) return colours.playerMissile;
        if (draw.monster) return colours.monster;
        if (draw.monsterMissile) return colours.monsterMissile;
        return background;
    endfunction

    task automatic setRow(input string name, input hitKind_t hit, input logic start,
                          input logic pauseIn, input logic cheat, input gameState_t state,
                          input stage_t stageIn, input logic [1:0] livesIn,
                          input scoreBcd_t scoreIn);
        scenarios.push_back({hit, start, pauseIn, cheat, state, stageIn, livesIn, scoreIn});
        rowNames.push_back(name);
    endtask

    task automatic fillScenarios();
        setRow("reset defaults", hitNone, 1'b0, 1'b0, 1'b1, idle, stageOne, 2'd3, 12'h000);
        setRow("start game", hitNone, 1'b1, 1'b0, 1'b1, play, stageOne, 2'd3, 12'h000);
        setRow("stage one kill 1", hitKill, 1'b0, 1'b0, 1'b1, play, stageOne, 2'd3, 12'h001);
        setRow("stage one kill 2", hitKill, 1'b0, 1'b0, 1'b1, play, stageOne, 2'd3, 12'h002);
        setRow("stage one kill 3", hitKill, 1'b0, 1'b0, 1'b1, play, stageOne, 2'd3, 12'h003);
        setRow("stage one kill 4", hitKill, 1'b0, 1'b0, 1'b1, play, stageTwo, 2'd3, 12'h004);
        setRow("stage two kill", hitKill, 1'b0, 1'b0, 1'b1, play, stageTwo, 2'd3, 12'h006);
        setRow("cheat to three", hitNone, 1'b0, 1'b0, 1'b0, play, stageThree, 2'd3, 12'h006);
        setRow("player hit", hitShot, 1'b0, 1'b0, 1'b1, play, stageThree, 2'd2, 12'h006);
        setRow("player rammed", hitRam, 1'b0, 1'b0, 1'b1, play, stageThree, 2'd1, 12'h006);
        setRow("last life lost", hitShot, 1'b0, 1'b0, 1'b1, over, stageThree, 2'd0, 12'h006);
        setRow("kill while over", hitKill, 1'b0, 1'b0, 1'b1, over, stageThree, 2'd0, 12'h006);
        setRow("restart", hitNone, 1'b1, 1'b0, 1'b1, play, stageOne, 2'd3, 12'h000);
        setRow("pause", hitNone, 1'b0, 1'b1, 1'b1, paused, stageOne, 2'd3, 12'h000);
        setRow("kill while paused", hitKill, 1'b0, 1'b0, 1'b1, paused, stageOne, 2'd3, 12'h000);
        setRow("resume", hitNone, 1'b0, 1'b1, 1'b1, play, stageOne, 2'd3, 12'h000);
        setRow("cheat to two", hitNone, 1'b0, 1'b0, 1'b0, play, stageTwo, 2'd3, 12'h000);
        setRow("cheat to three again", hitNone, 1'b0, 1'b0, 1'b0, play, stageThree, 2'd3,
               12'h000);
        setRow("missile out ignored", hitOut, 1'b0, 1'b0, 1'b1, play, stageThree, 2'd3, 12'h000);
        setRow("stage three kill", hitKill, 1'b0, 1'b0, 1'b1, play, stageThree, 2'd3, 12'h003);
        setRow("clear stage three", hitNone, 1'b0, 1'b0, 1'b0, won, stageThree, 2'd3, 12'h003);
    endtask

    // Buttons and overlap go into one frame and the check lands at the end of the next.
    task automatic runRow(input int r);
        scenario_t row;
        row = scenarios[r];
        waitForFrameStart(rowNames[r]);
        startGame = row.startGame;
        pause     = row.pause;
        cheatN    = row.cheatN;
        repeat (2) @(negedge clk);
        startGame = 1'b0;
        pause     = 1'b0;
        cheatN    = 1'b1;
        if (row.hit != hitNone) begin
            waitForPixel(HIT_X, HIT_Y);
            objDraw = drawFor(row.hit);
            @(negedge clk);
            objDraw = '0;
        end
        waitForFrameStart(rowNames[r]);
        waitForPixel(coord_t'(FRAME_WIDTH - 1), coord_t'(FRAME_HEIGHT - 1));
        checkState(rowNames[r], row.expState, gameState);
        checkStage(rowNames[r], row.expStage, stage);
        checkLives(rowNames[r], row.expLives, lives);
        checkScore(rowNames[r], row.expScore, score);
    endtask

    task automatic runMixerTrials();
        objDraw_t draw;
        objRgb_t  colours;
        rgb_t     background;
        rgb_t     expected;
        for (int i = 0; i < MIX_TRIALS; i++) begin
            draw          = 5'($urandom());
            colours       = {$urandom(), $urandom(), $urandom()};
            background    = 24'($urandom());
            objDraw       = draw;
            objRgb        = colours;
            backgroundRgb = background;
            expected      = expectedColour(draw, colours, background);
            @(negedge clk); // Mixer output is registered once.
            checkRgb($sformatf("mixer trial %0d", i), expected, pixelRgb);
        end
        objDraw = '0;
    endtask

    initial begin
        rstN          = 1'b0;
        startGame     = 1'b0;
        pause         = 1'b0;
        cheatN        = 1'b1;
        objDraw       = '0;
        objRgb        = '0;
        backgroundRgb = '0;
        void'($urandom(85));
        fillScenarios();
        repeat (10) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        for (int r = 0; r < scenarios.size(); r++) begin
            runRow(r);
        end
        runMixerTrials(); // The game sits in won here, so random overlaps are ignored.
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/gameController.sv ====
`default_nettype none
`timescale 1ns/1ps

module gameController (
    input  logic                clk,
    input  logic                rstN,
    input  logic                startGame,
    input  logic                pause,
    input  logic                cheatN,
    input  gamePkg::collision_t hitPulse,
    output gamePkg::gameState_t gameState,
    output gamePkg::stage_t     stage,
    output logic [1:0]          lives,
    output logic                killEvent,
    output logic                newGame
);

    import gamePkg::*;

    logic startPrev;
    logic pausePrev;
    logic cheatPrevN;
    logic startEdge;
    logic pauseEdge;
    logic cheatEdge;
    logic lifeLost;
    logic lastLife;
    logic stageDone;
    logic [$clog2(KILLS_PER_STAGE)-1:0] killCount;

    assign startEdge = startGame & ~startPrev;
    assign pauseEdge = pause & ~pausePrev;
    assign cheatEdge = ~cheatN & cheatPrevN; // Skip-stage cheat acts once per press.
    assign lifeLost  = hitPulse.playerHit | hitPulse.playerRammed;
    assign lastLife  = lifeLost && (lives == 2'd1);
    assign stageDone = cheatEdge ||
                       (hitPulse.missileHitsMonster && int'(killCount) == KILLS_PER_STAGE - 1);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            startPrev  <= 1'b0;
            pausePrev  <= 1'b0;
            cheatPrevN <= 1'b1;
            gameState  <= idle;
            stage      <= stageOne;
            lives      <= START_LIVES;
            killCount  <= '0;
            killEvent  <= 1'b0;
            newGame    <= 1'b0;
        end else begin
            startPrev  <= startGame;
            pausePrev  <= pause;
            cheatPrevN <= cheatN;
            killEvent  <= 1'b0;
            newGame    <= 1'b0;
            unique case (gameState)
                idle, won, over: begin
                    if (startEdge) begin
                        gameState <= play;
                        stage     <= stageOne;
                        lives     <= START_LIVES;
                        killCount <= '0;
                        newGame   <= 1'b1;
                    end
                end
                paused: begin
                    if (pauseEdge) gameState <= play;
                end
                play: begin
                    if (pauseEdge) begin
                        gameState <= paused;
                    end else begin
                        killEvent <= hitPulse.missileHitsMonster;
                        if (lifeLost) lives <= lives - 2'd1;
                        if (stageDone) begin
                            killCount <= '0;
                            if (stage == stageThree) gameState <= won;
                            else stage <= stage_t'(stage + 2'd1);
                        end else if (hitPulse.missileHitsMonster) begin
                            killCount <= killCount + 1'b1;
                        end
                        if (lastLife) gameState <= over; // Death outranks a stage clear.
                    end
                end
                default: gameState <= idle;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!rstN)
        killEvent |-> $past(gameState) == play);

endmodule

`default_nettype wire

// ==== rtl/gamePkg.sv ====
`default_nettype none

package gamePkg;

    typedef enum logic [2:0] {
        idle,
        play,
        paused,
        won,
        over
    } gameState_t;

    typedef enum logic [1:0] {
        stageOne,
        stageTwo,
        stageThree
    } stage_t;

    // One bit per overlap kind, reported once per frame.
    typedef struct packed {
        logic missileHitsMonster;
        logic playerHit;
        logic playerRammed;
        logic missileOut;
    } collision_t;

    localparam logic [1:0] START_LIVES = 2'd3;
    localparam int KILLS_PER_STAGE = 4;
    localparam logic [3:0] POINTS_PER_KILL = 4'd1; // Scaled by stage index plus one.

    typedef logic [3:0] bcdDigit_t;

    typedef struct packed {
        bcdDigit_t hundreds;
        bcdDigit_t tens;
        bcdDigit_t ones;
    } scoreBcd_t;

endpackage

`default_nettype wire

// ==== rtl/hitDetector.sv ====
`default_nettype none
`timescale 1ns/1ps

module hitDetector (
    input  logic                clk,
    input  logic                rstN,
    input  logic                startOfFrame,
    input  videoPkg::objDraw_t  objDraw,
    output gamePkg::collision_t hitPulse
);

    import gamePkg::*;

    collision_t overlap;
    collision_t frameAcc;

    always_comb begin
        overlap.missileHitsMonster = objDraw.playerMissile & objDraw.monster;
        overlap.playerHit          = objDraw.player & objDraw.monsterMissile;
        overlap.playerRammed       = objDraw.player & objDraw.monster;
        overlap.missileOut         = objDraw.playerMissile & objDraw.border;
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            frameAcc <= '0;
            hitPulse <= '0;
        end else if (startOfFrame) begin
            hitPulse <= frameAcc; // Report the frame that just ended.
            frameAcc <= overlap;  // Pixel (0,0) opens the new frame.
        end else begin
            hitPulse <= '0;
            frameAcc <= frameAcc | overlap;
        end
    end

    // Collisions are reported once per frame, right after its boundary.
    assert property (@(posedge clk) disable iff (!rstN)
        (hitPulse != '0) |-> $past(startOfFrame));

endmodule

`default_nettype wire

// ==== rtl/invadersCore.sv ====
`default_nettype none
`timescale 1ns/1ps

module invadersCore #(
    parameter int FRAME_WIDTH  = 640,
    parameter int FRAME_HEIGHT = 480
) (
    input  logic                clk,
    input  logic                rstN,
    input  logic                startGame,
    input  logic                pause,
    input  logic                cheatN,
    input  videoPkg::objDraw_t  objDraw,
    input  videoPkg::objRgb_t   objRgb,
    input  videoPkg::rgb_t      backgroundRgb,
    output videoPkg::coord_t    pixelX,
    output videoPkg::coord_t    pixelY,
    output logic                startOfFrame,
    output videoPkg::rgb_t      pixelRgb,
    output gamePkg::gameState_t gameState,
    output gamePkg::stage_t     stage,
    output logic [1:0]          lives,
    output gamePkg::scoreBcd_t  score
);

    import gamePkg::*;

    collision_t hitPulse;
    logic       killEvent;
    logic       newGame;

    rasterScanner #(
        .FRAME_WIDTH  (FRAME_WIDTH),
        .FRAME_HEIGHT (FRAME_HEIGHT)
    ) i_rasterScanner (
        .clk          (clk),
        .rstN         (rstN),
        .pixelX       (pixelX),
        .pixelY       (pixelY),
        .startOfFrame (startOfFrame)
    );

    hitDetector i_hitDetector (
        .clk          (clk),
        .rstN         (rstN),
        .startOfFrame (startOfFrame),
        .objDraw      (objDraw),
        .hitPulse     (hitPulse)
    );

    pixelMixer i_pixelMixer (
        .clk           (clk),
        .rstN          (rstN),
        .objDraw       (objDraw),
        .objRgb        (objRgb),
        .backgroundRgb (backgroundRgb),
        .pixelRgb      (pixelRgb)
    );

    gameController i_gameController (
        .clk       (clk),
        .rstN      (rstN),
        .startGame (startGame),
        .pause     (pause),
        .cheatN    (cheatN),
        .hitPulse  (hitPulse),
        .gameState (gameState),
        .stage     (stage),
        .lives     (lives),
        .killEvent (killEvent),
        .newGame   (newGame)
    );

    scoreCounter i_scoreCounter (
        .clk       (clk),
        .rstN      (rstN),
        .killEvent (killEvent),
        .newGame   (newGame),
        .stage     (stage),
        .score     (score)
    );

endmodule

`default_nettype wire

// ==== rtl/pixelMixer.sv ====
`default_nettype none
`timescale 1ns/1ps

module pixelMixer (
    input  logic               clk,
    input  logic               rstN,
    input  videoPkg::objDraw_t objDraw,
    input  videoPkg::objRgb_t  objRgb,
    input  videoPkg::rgb_t     backgroundRgb,
    output videoPkg::rgb_t     pixelRgb
);

    import videoPkg::*;

    rgb_t mixRgb;

    // The border never draws, it only feeds hit detection.
    always_comb begin
        if (objDraw.player) begin
            mixRgb = objRgb.player;
        end else if (objDraw.playerMissile) begin
            mixRgb = objRgb.playerMissile;
        end else if (objDraw.monster) begin
            mixRgb = objRgb.monster;
        end else if (objDraw.monsterMissile) begin
            mixRgb = objRgb.monsterMissile;
        end else begin
            mixRgb = backgroundRgb;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pixelRgb <= '0; // Black.
        end else begin
            pixelRgb <= mixRgb;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/rasterScanner.sv ====
`default_nettype none
`timescale 1ns/1ps

module rasterScanner #(
    parameter int FRAME_WIDTH  = 640,
    parameter int FRAME_HEIGHT = 480
) (
    input  logic            clk,
    input  logic            rstN,
    output videoPkg::coord_t pixelX,
    output videoPkg::coord_t pixelY,
    output logic            startOfFrame
);

    import videoPkg::*;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pixelX <= '0;
            pixelY <= '0;
        end else if (pixelX == coord_t'(FRAME_WIDTH - 1)) begin
            pixelX <= '0;
            if (pixelY == coord_t'(FRAME_HEIGHT - 1)) begin
                pixelY <= '0; // Wrap to the top left corner.
            end else begin
                pixelY <= pixelY + coord_t'(1);
            end
        end else begin
            pixelX <= pixelX + coord_t'(1);
        end
    end

    assign startOfFrame = (pixelX == '0) && (pixelY == '0); // High while pixel (0,0) is shown.

    assert property (@(posedge clk) disable iff (!rstN)
        pixelX < FRAME_WIDTH);

endmodule

`default_nettype wire

// ==== rtl/scoreCounter.sv ====
`default_nettype none
`timescale 1ns/1ps

module scoreCounter (
    input  logic               clk,
    input  logic               rstN,
    input  logic               killEvent,
    input  logic               newGame,
    input  gamePkg::stage_t    stage,
    output gamePkg::scoreBcd_t score
);

    import gamePkg::*;

    stage_t    killStage;
    logic [3:0] points;
    logic [4:0] onesSum;
    logic [4:0] tensSum;
    logic [4:0] hundredsSum;
    logic       onesCarry;
    logic       tensCarry;
    scoreBcd_t  nextScore;

    always_comb begin
        points      = POINTS_PER_KILL * (4'(killStage) + 4'd1);
        onesSum     = 5'(score.ones) + 5'(points);
        onesCarry   = onesSum > 5'd9;
        tensSum     = 5'(score.tens) + 5'(onesCarry);
        tensCarry   = tensSum > 5'd9;
        hundredsSum = 5'(score.hundreds) + 5'(tensCarry);
        if (hundredsSum > 5'd9) begin
            nextScore = '{4'd9, 4'd9, 4'd9}; // Saturate at 999.
        end else begin
            nextScore.hundreds = hundredsSum[3:0];
            nextScore.tens     = tensCarry ? 4'(tensSum - 5'd10) : tensSum[3:0];
            nextScore.ones     = onesCarry ? 4'(onesSum - 5'd10) : onesSum[3:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            killStage <= stageOne;
            score     <= '0;
        end else begin
            killStage <= stage; // Stage in force when the kill was counted.
            if (newGame) begin
                score <= '0;
            end else if (killEvent) begin
                score <= nextScore;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/videoPkg.sv ====
`default_nettype none

package videoPkg;

    localparam int COORD_WIDTH = 10; // Covers 640 columns and 480 rows.

    typedef logic [COORD_WIDTH-1:0] coord_t;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

    // Field order is the display priority, highest first.
    typedef struct packed {
        logic player;
        logic playerMissile;
        logic monster;
        logic monsterMissile;
        logic border; // Hit detection only.
    } objDraw_t;

    typedef struct packed {
        rgb_t player;
        rgb_t playerMissile;
        rgb_t monster;
        rgb_t monsterMissile;
    } objRgb_t;

endpackage

`default_nettype wire

// ==== verilog.f ====
rtl/videoPkg.sv
rtl/gamePkg.sv
rtl/rasterScanner.sv
rtl/hitDetector.sv
rtl/pixelMixer.sv
rtl/gameController.sv
rtl/scoreCounter.sv
rtl/invadersCore.sv
dv/invadersCoreTb.sv
